// File: hw/itlb_cfg.svh
// Instruction TLB build parameters
// ITLB_ENTRIES must be a power of two, 2 or more
// ITLB_PPN_W must not be smaller than ITLB_VPN_W
// so that the identity mapping with vmem off fits

`ifndef ITLB_CFG_SVH
`define ITLB_CFG_SVH

`default_nettype none

// Number of fully associative entries
`define ITLB_ENTRIES 4

// Virtual page number width (Sv32-like 4 KiB pages)
`define ITLB_VPN_W 20

// Physical page number width
`define ITLB_PPN_W 22

`default_nettype wire

`endif

// File: hw/itlb_pkg.sv
// Shared types of the instruction TLB
// Widths come from the config header
// No ASID or permission bits are carried

`include "itlb_cfg.svh"

`default_nettype none

package itlb_pkg;

  // Exception attached to a request or an answer
  typedef enum logic [1:0] {
    ExcNone        = 2'd0,
    ExcMisaligned  = 2'd1,
    ExcAccessFault = 2'd2,
    ExcPageFault   = 2'd3
  } itlb_exc_e;

  // Miss handling states
  typedef enum logic [1:0] {
    StReady  = 2'd0,
    StL2Req  = 2'd1,
    StL2Wait = 2'd2
  } itlb_state_e;

  // Request from the instruction cache
  typedef struct packed {
    logic [`ITLB_VPN_W-1:0] vpn;
    itlb_exc_e              exc;
  } itlb_req_t;

  // Answer back to the instruction cache
  typedef struct packed {
    logic [`ITLB_PPN_W-1:0] ppn;
    itlb_exc_e              exc;
  } itlb_ans_t;

  // Miss request towards L2 TLB or walker
  typedef struct packed {
    logic [`ITLB_VPN_W-1:0] vpn;
  } l2_req_t;

  // L2 answer, only cached when exc is ExcNone
  typedef struct packed {
    logic [`ITLB_PPN_W-1:0] ppn;
    itlb_exc_e              exc;
  } l2_ans_t;

endpackage

`default_nettype wire

// File: hw/itlb_array.sv
// Fully associative translation store
// Hit and PPN are combinational from the lookup VPN
// Victim choice is plain round-robin, not LRU
// A flush wins over a refill in the same cycle
// At most one entry matches a VPN, since refills only follow misses

`timescale 1ns/1ps

`include "itlb_cfg.svh"

`default_nettype none

module itlb_array (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   flush_i,
  // Lookup side
  input  wire logic                   lookup_i,
  input  wire logic [`ITLB_VPN_W-1:0] lookup_vpn_i,
  // Refill from the L2 answer
  input  wire logic                   refill_i,
  input  wire itlb_pkg::l2_ans_t      refill_ans_i,
  output      logic                   hit_o,
  output      logic [`ITLB_PPN_W-1:0] hit_ppn_o,
  output      logic [`ITLB_VPN_W-1:0] miss_vpn_o
);

  localparam int unsigned IdxW = $clog2(`ITLB_ENTRIES);

  // Entry storage, tags and PPNs carry no reset
  logic [`ITLB_VPN_W-1:0] tag_q [`ITLB_ENTRIES];
  logic [`ITLB_PPN_W-1:0] ppn_q [`ITLB_ENTRIES];
  logic [`ITLB_ENTRIES-1:0] valid_q;

  // Round-robin victim pointer
  logic [IdxW-1:0] rr_q;

  // VPN of the last accepted lookup
  logic [`ITLB_VPN_W-1:0] miss_vpn_q;

  logic [`ITLB_ENTRIES-1:0] hit_vec;
  logic                     write_en;

  // Parallel tag compare
  always_comb begin
    for (int i = 0; i < `ITLB_ENTRIES; i++) begin
      hit_vec[i] = valid_q[i] && (tag_q[i] == lookup_vpn_i);
    end
  end

  assign hit_o = |hit_vec;

  // Select the matching PPN
  always_comb begin
    hit_ppn_o = '0;
    for (int i = 0; i < `ITLB_ENTRIES; i++) begin
      if (hit_vec[i]) begin
        hit_ppn_o = ppn_q[i];
      end
    end
  end

  // Faulting answers are never cached
  assign write_en = refill_i && !flush_i && (refill_ans_i.exc == itlb_pkg::ExcNone);

  // Remember the looked-up VPN, it becomes the L2 request on a miss
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_vpn_q <= '0;
    end else if (lookup_i) begin
      miss_vpn_q <= lookup_vpn_i;
    end
  end

  assign miss_vpn_o = miss_vpn_q;

  // Valid bits and victim pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      // Drop every translation
      valid_q <= '0;
    end else if (write_en) begin
      valid_q[rr_q] <= 1'b1;
      // Wraps on its own since the entry count is a power of two
      rr_q          <= rr_q + 1'b1;
    end
  end

  // Tag and PPN write into the victim slot
  always_ff @(posedge clk_i) begin
    if (write_en) begin
      tag_q[rr_q] <= miss_vpn_q;
      ppn_q[rr_q] <= refill_ans_i.ppn;
    end
  end

endmodule

`default_nettype wire

// File: hw/itlb_ctrl.sv
// Moore control of the instruction TLB miss path
// One outstanding miss at most, new requests held off meanwhile
// Abort overrides every transition and drops the pending answer

`timescale 1ns/1ps

`default_nettype none

module itlb_ctrl (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                abort_i,
  input  wire logic                vmem_on_i,
  // Conditions for leaving StReady
  input  wire logic                req_valid_i,
  input  wire itlb_pkg::itlb_exc_e req_exc_i,
  input  wire logic                hit_i,
  // L2 handshake inputs
  input  wire logic                l2_req_rdy_i,
  input  wire logic                l2_ans_valid_i,
  output      logic                ready_o,
  output      logic                l2_req_valid_o,
  output      logic                l2_ans_rdy_o,
  output      logic                refill_o,
  output      logic                waiting_o
);

  itlb_pkg::itlb_state_e state_d, state_q;

  logic miss;

  // True miss: accepted translated request without exception or hit
  assign miss = req_valid_i && vmem_on_i && (req_exc_i == itlb_pkg::ExcNone) && !hit_i;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      itlb_pkg::StReady: begin
        if (miss) begin
          state_d = itlb_pkg::StL2Req;
        end
      end
      itlb_pkg::StL2Req: begin
        // Request held until L2 takes it
        if (l2_req_rdy_i) begin
          state_d = itlb_pkg::StL2Wait;
        end
      end
      itlb_pkg::StL2Wait: begin
        if (l2_ans_valid_i) begin
          state_d = itlb_pkg::StReady;
        end
      end
      default: begin
        state_d = itlb_pkg::StReady;
      end
    endcase
    // Abort beats everything
    if (abort_i) begin
      state_d = itlb_pkg::StReady;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= itlb_pkg::StReady;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs decoded from the state only
  assign ready_o        = (state_q == itlb_pkg::StReady);
  assign l2_req_valid_o = (state_q == itlb_pkg::StL2Req);
  assign l2_ans_rdy_o   = (state_q == itlb_pkg::StL2Wait);
  assign waiting_o      = (state_q == itlb_pkg::StL2Wait);

  // L2 answer taken, unless the miss is being aborted
  assign refill_o = waiting_o && l2_ans_valid_i && !abort_i;

endmodule

`default_nettype wire

// File: hw/itlb.sv
// Instruction TLB top
// Answers one cycle after acceptance, or one cycle after the L2 answer
// The cache side has no back-pressure, ans_valid_o is a single pulse
// Identity mapping with vmem off zero-extends the VPN

`timescale 1ns/1ps

`include "itlb_cfg.svh"

`default_nettype none

module itlb (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                flush_i,
  input  wire logic                abort_i,
  input  wire logic                vmem_on_i,
  // Cache request side
  input  wire logic                req_valid_i,
  input  wire itlb_pkg::itlb_req_t req_i,
  output      logic                ready_o,
  output      logic                ans_valid_o,
  output      itlb_pkg::itlb_ans_t ans_o,
  // L2 side
  output      logic                l2_req_valid_o,
  output      itlb_pkg::l2_req_t   l2_req_o,
  input  wire logic                l2_req_rdy_i,
  output      logic                l2_ans_rdy_o,
  input  wire logic                l2_ans_valid_i,
  input  wire itlb_pkg::l2_ans_t   l2_ans_i
);

  logic                   accept;
  logic                   hit;
  logic [`ITLB_PPN_W-1:0] hit_ppn;
  logic [`ITLB_VPN_W-1:0] miss_vpn;
  logic                   refill;
  logic                   waiting;

  itlb_pkg::itlb_ans_t ans_d, ans_q;
  logic                ans_valid_d, ans_valid_q;

  assign accept = req_valid_i && ready_o;

  itlb_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .abort_i        (abort_i),
    .vmem_on_i      (vmem_on_i),
    .req_valid_i    (accept),
    .req_exc_i      (req_i.exc),
    .hit_i          (hit),
    .l2_req_rdy_i   (l2_req_rdy_i),
    .l2_ans_valid_i (l2_ans_valid_i),
    .ready_o        (ready_o),
    .l2_req_valid_o (l2_req_valid_o),
    .l2_ans_rdy_o   (l2_ans_rdy_o),
    .refill_o       (refill),
    .waiting_o      (waiting)
  );

  itlb_array u_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .lookup_i     (accept),
    .lookup_vpn_i (req_i.vpn),
    .refill_i     (refill),
    .refill_ans_i (l2_ans_i),
    .hit_o        (hit),
    .hit_ppn_o    (hit_ppn),
    .miss_vpn_o   (miss_vpn)
  );

  // Answer source select
  always_comb begin
    ans_d       = '{ppn: '0, exc: itlb_pkg::ExcNone};
    ans_valid_d = 1'b0;
    if (waiting) begin
      // L2 answer, faults included
      ans_d.ppn   = l2_ans_i.ppn;
      ans_d.exc   = l2_ans_i.exc;
      ans_valid_d = refill;
    end else if (accept) begin
      if (req_i.exc != itlb_pkg::ExcNone) begin
        // Exception passed back, no lookup
        ans_d.exc   = req_i.exc;
        ans_valid_d = 1'b1;
      end else if (!vmem_on_i) begin
        ans_d.ppn   = {{(`ITLB_PPN_W - `ITLB_VPN_W){1'b0}}, req_i.vpn};
        ans_valid_d = 1'b1;
      end else if (hit) begin
        ans_d.ppn   = hit_ppn;
        ans_valid_d = 1'b1;
      end
    end
  end

  // Valid pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ans_valid_q <= 1'b0;
    end else begin
      ans_valid_q <= ans_valid_d;
    end
  end

  // Answer payload, loaded only with a valid answer
  always_ff @(posedge clk_i) begin
    if (ans_valid_d) begin
      ans_q <= ans_d;
    end
  end

  assign ans_valid_o = ans_valid_q;
  assign ans_o       = ans_q;

  // Miss VPN held stable through StL2Req
  assign l2_req_o.vpn = miss_vpn;

endmodule

`default_nettype wire

// File: bench/itlb_props.sv
// Assertions on the miss control, bound into itlb_ctrl
// Written for one outstanding miss at a time

`timescale 1ns/1ps

`default_nettype none

module itlb_props (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire logic                  abort_i,
  input wire logic                  req_valid_i,
  input wire logic                  l2_req_rdy_i,
  input wire logic                  l2_ans_valid_i,
  input wire logic                  ready_o,
  input wire logic                  l2_req_valid_o,
  input wire logic                  l2_ans_rdy_o,
  input wire logic                  refill_o,
  input wire itlb_pkg::itlb_state_e state_q
);

  // L2 request stays up until L2 takes it
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_req_valid_o && !l2_req_rdy_i && !abort_i |=> l2_req_valid_o)
    else $error("L2 request dropped before L2 took it");

  // No new requests until the L2 answer or an abort ends the miss
  ready_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !ready_o && !abort_i && !(l2_ans_rdy_o && l2_ans_valid_i) |=> !ready_o)
    else $error("ready_o rose before the miss ended");

  // A miss only starts from an accepted request
  miss_accepted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == itlb_pkg::StL2Req && $past(state_q) == itlb_pkg::StReady)
    |-> $past(req_valid_i))
    else $error("miss started without an accepted request");

  // Ready again in the cycle that carries the miss answer
  refill_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_o |=> ready_o)
    else $error("ready_o low when the miss answer went out");

endmodule

bind itlb_ctrl itlb_props props_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .abort_i        (abort_i),
  .req_valid_i    (req_valid_i),
  .l2_req_rdy_i   (l2_req_rdy_i),
  .l2_ans_valid_i (l2_ans_valid_i),
  .ready_o        (ready_o),
  .l2_req_valid_o (l2_req_valid_o),
  .l2_ans_rdy_o   (l2_ans_rdy_o),
  .refill_o       (refill_o),
  .state_q        (state_q)
);

`default_nettype wire

// File: bench/itlb_checker.sv
// Watches the instruction TLB ports and compares every answer
// Expected values assume the L2 model rule PPN = VPN ^ l2_xor
// At most one miss is open, so the queues hold one entry at a time

`timescale 1ns/1ps

`include "itlb_cfg.svh"

`default_nettype none

module itlb_checker #(
  parameter logic [`ITLB_PPN_W-1:0] l2_xor = 22'h2A5A5
) (
  input wire logic                clk_i,
  input wire logic                rst_ni,
  input wire logic                abort_i,
  input wire logic                vmem_on_i,
  input wire logic                req_valid_i,
  input wire itlb_pkg::itlb_req_t req_i,
  input wire logic                ready_i,
  input wire logic                ans_valid_i,
  input wire itlb_pkg::itlb_ans_t ans_i,
  input wire logic                l2_req_valid_i,
  input wire itlb_pkg::l2_req_t   l2_req_i,
  input wire logic                l2_req_rdy_i
);

  typedef logic [`ITLB_VPN_W-1:0] vpn_t;

  // Expected answers and VPNs of accepted requests
  itlb_pkg::itlb_ans_t exp_q[$];
  vpn_t                vpn_q[$];

  int err_cnt    = 0;
  int ans_cnt    = 0;
  int l2_req_cnt = 0;

  // Expected answer for one request
  function automatic itlb_pkg::itlb_ans_t ref_answer(input vpn_t vpn, input logic vmem,
                                                     input itlb_pkg::itlb_exc_e exc);
    itlb_pkg::itlb_ans_t a;
    a.ppn = {{(`ITLB_PPN_W - `ITLB_VPN_W){1'b0}}, vpn};
    a.exc = itlb_pkg::ExcNone;
    if (exc != itlb_pkg::ExcNone) begin
      // Request exception comes back with a zero PPN
      a.ppn = '0;
      a.exc = exc;
    end else if (vmem) begin
      a.ppn = a.ppn ^ l2_xor;
      if (vpn[3:0] == 4'hF) begin
        a.exc = itlb_pkg::ExcPageFault;
      end
    end
    return a;
  endfunction

  // Pre-edge values, inputs move only on the falling edge
  always @(posedge clk_i or negedge rst_ni) begin : compare
    itlb_pkg::itlb_ans_t exp_ans;
    if (!rst_ni) begin
      exp_q.delete();
      vpn_q.delete();
    end else begin
      if (ans_valid_i) begin
        if (exp_q.size() == 0) begin
          $display("answer arrived at %0t without an accepted request", $time);
          err_cnt++;
        end else begin
          exp_ans = exp_q.pop_front();
          void'(vpn_q.pop_front());
          ans_cnt++;
          if (ans_i !== exp_ans) begin
            $display("mismatch at %0t: answer ppn %h exc %0d, expected ppn %h exc %0d",
                     $time, ans_i.ppn, ans_i.exc, exp_ans.ppn, exp_ans.exc);
            err_cnt++;
          end
        end
      end
      // Aborted miss never answers
      if (abort_i && !ready_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        void'(vpn_q.pop_front());
      end
      if (l2_req_valid_i && l2_req_rdy_i) begin
        l2_req_cnt++;
        if (vpn_q.size() == 0) begin
          $display("L2 request at %0t without a pending miss", $time);
          err_cnt++;
        end else if (l2_req_i.vpn !== vpn_q[0]) begin
          $display("mismatch at %0t: L2 request vpn %h, expected %h",
                   $time, l2_req_i.vpn, vpn_q[0]);
          err_cnt++;
        end
      end
      if (req_valid_i && ready_i) begin
        exp_q.push_back(ref_answer(req_i.vpn, vmem_on_i, req_i.exc));
        vpn_q.push_back(req_i.vpn);
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/itlb_tb.sv
// Testbench for the instruction TLB
// L2 model answers PPN = VPN ^ 22'h2A5A5, page fault when the VPN ends in 4'hF
// Inputs change on the falling edge
// The checker samples on the rising edge

`timescale 1ns/1ps

`include "itlb_cfg.svh"

`default_nettype none

module itlb_tb;

  typedef logic [`ITLB_VPN_W-1:0] vpn_t;

  localparam int reset_cycles = 10;
  // Requests over all tests
  localparam int num_reqs     = 18 + 2 * `ITLB_ENTRIES;
  localparam int limit_cycles = num_reqs * 20 + reset_cycles;
  localparam logic [`ITLB_PPN_W-1:0] l2_xor = 22'h2A5A5;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                flush_i;
  logic                abort_i;
  logic                vmem_on_i;
  logic                req_valid_i;
  itlb_pkg::itlb_req_t req_i;
  logic                ready_o;
  logic                ans_valid_o;
  itlb_pkg::itlb_ans_t ans_o;
  logic                l2_req_valid_o;
  itlb_pkg::l2_req_t   l2_req_o;
  logic                l2_req_rdy_i;
  logic                l2_ans_rdy_o;
  logic                l2_ans_valid_i;
  itlb_pkg::l2_ans_t   l2_ans_i;

  // Holds the L2 answer back so a miss can be aborted
  logic hold_ans;
  int   tb_errs   = 0;
  int   num_tests = 0;
  int   cycle_cnt = 0;

  always #50 clk_i = ~clk_i;

  itlb itlb_i (.*);

  itlb_checker #(.l2_xor(l2_xor)) chk_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .abort_i        (abort_i),
    .vmem_on_i      (vmem_on_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .ready_i        (ready_o),
    .ans_valid_i    (ans_valid_o),
    .ans_i          (ans_o),
    .l2_req_valid_i (l2_req_valid_o),
    .l2_req_i       (l2_req_o),
    .l2_req_rdy_i   (l2_req_rdy_i)
  );

  // L2 model with random ready and 0 to 5 cycles of answer delay
  initial begin : l2_model
    logic pending;
    vpn_t pend_vpn;
    int   delay;
    pending        = 1'b0;
    pend_vpn       = '0;
    delay          = 0;
    l2_req_rdy_i   = 1'b0;
    l2_ans_valid_i = 1'b0;
    l2_ans_i       = '0;
    forever begin
      @(negedge clk_i);
      l2_ans_valid_i = 1'b0;
      if (pending && l2_ans_rdy_o) begin
        if (delay == 0 && !hold_ans) begin
          l2_ans_valid_i = 1'b1;
          l2_ans_i.ppn   = {{(`ITLB_PPN_W - `ITLB_VPN_W){1'b0}}, pend_vpn} ^ l2_xor;
          l2_ans_i.exc   = (pend_vpn[3:0] == 4'hF) ? itlb_pkg::ExcPageFault : itlb_pkg::ExcNone;
          pending        = 1'b0;
        end else if (delay > 0) begin
          delay--;
        end
      end else if (pending && !l2_req_valid_o) begin
        // Miss was aborted
        pending = 1'b0;
      end
      l2_req_rdy_i = 1'($urandom_range(1, 0));
      // Request is taken at the next rising edge
      if (l2_req_valid_o && l2_req_rdy_i && !pending) begin
        pending  = 1'b1;
        pend_vpn = l2_req_o.vpn;
        delay    = int'($urandom_range(5, 0));
      end
    end
  end

  function automatic int total_errs();
    return tb_errs + chk_i.err_cnt;
  endfunction

  // Sends one request and waits for its answer
  // exp_l2 is the number of L2 requests it should cause
  task automatic run_req(input vpn_t vpn, input itlb_pkg::itlb_exc_e exc, input int exp_l2);
    int l2_before;
    int lat;
    l2_before = chk_i.l2_req_cnt;
    while (!ready_o) @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = '{vpn: vpn, exc: exc};
    @(negedge clk_i);
    req_valid_i = 1'b0;
    lat         = 1;
    while (!ans_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    if (chk_i.l2_req_cnt - l2_before != exp_l2) begin
      $display("mismatch at %0t: vpn %h made %0d L2 requests, expected %0d",
               $time, vpn, chk_i.l2_req_cnt - l2_before, exp_l2);
      tb_errs++;
    end
    if (exp_l2 == 0 && lat != 1) begin
      $display("mismatch at %0t: vpn %h answered after %0d cycles, expected 1", $time, vpn, lat);
      tb_errs++;
    end
  endtask

  task automatic do_flush();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    // Let the checker compare the last answer of the test
    @(negedge clk_i);
    num_tests++;
    if (total_errs() == errs_before) begin
      $display("test %0d %s: pass", num_tests, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", num_tests, name, total_errs() - errs_before);
    end
  endtask

  initial begin
    logic [15:0] base;
    vpn_t        vpn_a;
    vpn_t        rr_vpn [`ITLB_ENTRIES+1];
    int          errs;
    int          l2_before;
    void'($urandom(32'h075b_cdc1));
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    abort_i     = 1'b0;
    vmem_on_i   = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    hold_ans    = 1'b0;
    repeat (reset_cycles) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Idle outputs right after reset
    errs = total_errs();
    if (ready_o !== 1'b1 || ans_valid_o !== 1'b0 || l2_req_valid_o !== 1'b0 ||
        l2_ans_rdy_o !== 1'b0) begin
      $display("mismatch at %0t: after reset ready %b ans_valid %b l2_req_valid %b l2_ans_rdy %b",
               $time, ready_o, ans_valid_o, l2_req_valid_o, l2_ans_rdy_o);
      tb_errs++;
    end
    report_test("reset", errs);

    // Identity mapping with no L2 traffic
    errs = total_errs();
    for (int i = 0; i < 6; i++) begin
      run_req(vpn_t'($urandom), itlb_pkg::ExcNone, 0);
    end
    report_test("vmem off", errs);

    // Miss fills an entry and the repeat hits
    errs      = total_errs();
    vmem_on_i = 1'b1;
    vpn_a     = {16'($urandom), 4'h3};
    run_req(vpn_a, itlb_pkg::ExcNone, 1);
    run_req(vpn_a, itlb_pkg::ExcNone, 0);
    vpn_a = vpn_a ^ 20'h10;
    run_req(vpn_a, itlb_pkg::ExcNone, 1);
    run_req(vpn_a, itlb_pkg::ExcNone, 0);
    report_test("miss then hit", errs);

    // Faults are returned but never cached
    errs  = total_errs();
    vpn_a = {16'($urandom), 4'hF};
    run_req(vpn_a, itlb_pkg::ExcNone, 1);
    run_req(vpn_a, itlb_pkg::ExcNone, 1);
    report_test("page fault not cached", errs);

    errs = total_errs();
    run_req(vpn_t'($urandom), itlb_pkg::ExcMisaligned, 0);
    run_req(vpn_t'($urandom), itlb_pkg::ExcAccessFault, 0);
    report_test("request exception", errs);

    // One more VPN than entries wraps the victim pointer
    errs = total_errs();
    do_flush();
    base = 16'($urandom);
    for (int i = 0; i <= `ITLB_ENTRIES; i++) begin
      rr_vpn[i] = {base + 16'(i), 4'h2};
      run_req(rr_vpn[i], itlb_pkg::ExcNone, 1);
    end
    // First VPN was overwritten by the last refill
    run_req(rr_vpn[0], itlb_pkg::ExcNone, 1);
    run_req(rr_vpn[2], itlb_pkg::ExcNone, 0);
    do_flush();
    for (int i = 2; i <= `ITLB_ENTRIES; i++) begin
      run_req(rr_vpn[i], itlb_pkg::ExcNone, 1);
    end
    report_test("round-robin and flush", errs);

    // Abort while waiting on L2
    errs      = total_errs();
    hold_ans  = 1'b1;
    vpn_a     = {16'($urandom), 4'h5};
    l2_before = chk_i.l2_req_cnt;
    while (!ready_o) @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = '{vpn: vpn_a, exc: itlb_pkg::ExcNone};
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (!l2_ans_rdy_o) @(negedge clk_i);
    abort_i = 1'b1;
    @(negedge clk_i);
    abort_i  = 1'b0;
    hold_ans = 1'b0;
    if (!ready_o) begin
      $display("ready_o still low one cycle after abort at %0t", $time);
      tb_errs++;
    end
    repeat (4) begin
      if (ans_valid_o) begin
        $display("answer appeared at %0t for an aborted miss", $time);
        tb_errs++;
      end
      @(negedge clk_i);
    end
    if (chk_i.l2_req_cnt - l2_before != 1) begin
      $display("mismatch at %0t: aborted miss made %0d L2 requests, expected 1",
               $time, chk_i.l2_req_cnt - l2_before);
      tb_errs++;
    end
    run_req(vpn_a ^ 20'h20, itlb_pkg::ExcNone, 1);
    report_test("abort", errs);

    repeat (3) @(negedge clk_i);
    $display("summary: %0d tests, %0d answers, %0d L2 requests, %0d errors",
             num_tests, chk_i.ans_cnt, chk_i.l2_req_cnt, total_errs());
    if (total_errs() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the request count
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= limit_cycles) begin
      $display("timeout, run did not end within %0d cycles", limit_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: itlb.f
+incdir+hw
hw/itlb_pkg.sv
hw/itlb_array.sv
hw/itlb_ctrl.sv
hw/itlb.sv
bench/itlb_props.sv
bench/itlb_checker.sv
bench/itlb_tb.sv

// File: Makefile
# Verilator simulation of the instruction TLB
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= itlb_tb
FILELIST  ?= itlb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
